/* source/glb_param_pkg.sv */
// sizes shared by every tile of the ring
// NUM_TILES must be even so that the end tile is an odd tile
// BANK_DEPTH must equal 2**BANK_ADDR_WIDTH
`default_nettype none

package glb_param_pkg;

    // tiles in the ring
    localparam int NUM_TILES = 4;

    // tile index, wide enough for NUM_TILES
    localparam int TILE_ID_WIDTH = 2;

    // word address inside one bank
    localparam int BANK_ADDR_WIDTH = 6;

    // words per bank
    localparam int BANK_DEPTH = 64;

    // data word carried by packets and stored in banks
    localparam int DATA_WIDTH = 16;

endpackage

`default_nettype wire

/* source/glb_packet_pkg.sv */
// packet format of the ring, 28 bits wide
// PKT_NONE is all zero so a cleared register is an empty slot
`default_nettype none

package glb_packet_pkg;

    import glb_param_pkg::*;

    // packet opcodes
    typedef enum logic [1:0] {
        PKT_NONE = 2'd0,
        PKT_WR   = 2'd1,
        PKT_RD   = 2'd2,
        PKT_RSP  = 2'd3
    } pkt_kind_e;

    // one ring slot
    typedef struct packed {
        // opcode, PKT_NONE for an empty slot
        pkt_kind_e                  kind;
        // tile that issued the request, also the response target
        logic [TILE_ID_WIDTH-1:0]   src;
        // tile owning the address
        logic [TILE_ID_WIDTH-1:0]   dst;
        // word address in the owning bank
        logic [BANK_ADDR_WIDTH-1:0] addr;
        // write data, or read data in a response
        logic [DATA_WIDTH-1:0]      data;
    } packet_t;

endpackage

`default_nettype wire

/* source/glb_bank_if.sv */
// link between a core switch and its memory bank
// strobes are single cycle, read data follows one cycle after rd_en
`timescale 1ns/1ps
`default_nettype none

interface glb_bank_if;

    import glb_param_pkg::*;

    // driven by the switch
    logic                       wr_en;
    logic                       rd_en;
    logic [BANK_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]      wr_data;

    // driven by the bank
    logic [DATA_WIDTH-1:0]      rd_data;

    // switch side
    modport ctrl (
        output wr_en, rd_en, addr, wr_data,
        input  rd_data
    );

    // memory side
    modport mem (
        input  wr_en, rd_en, addr, wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

/* source/glb_core_strm_router.sv */
// even tiles move packets west to east, odd tiles east to west
// tile 0 turns the ring at its west side, tile NUM_TILES-1 at its east side
// the unused outer input of a turnaround tile is ignored
`timescale 1ns/1ps
`default_nettype none

module glb_core_strm_router #(
    parameter logic [glb_param_pkg::TILE_ID_WIDTH-1:0] tile_id = '0
) (
    input  logic                    clk,
    input  logic                    clk_en,
    input  logic                    reset,

    input  glb_packet_pkg::packet_t packet_w2e_wsti,
    output glb_packet_pkg::packet_t packet_e2w_wsto,
    input  glb_packet_pkg::packet_t packet_e2w_esti,
    output glb_packet_pkg::packet_t packet_w2e_esto,
    input  glb_packet_pkg::packet_t packet_sw2sr,
    output glb_packet_pkg::packet_t packet_sr2sw
);

    import glb_param_pkg::*;
    import glb_packet_pkg::*;

    // role of this tile, fixed at elaboration
    localparam logic IS_EVEN  = (tile_id[0] == 1'b0);
    localparam logic IS_START = (tile_id == '0);
    localparam logic IS_END   = (int'(tile_id) == NUM_TILES - 1);

    packet_t w2e_wsti_turned;
    packet_t e2w_esti_turned;
    packet_t w2e_esto_int;
    packet_t e2w_wsto_int;
    packet_t sw2sr_q;

    // start tile loops its own west output back in
    assign w2e_wsti_turned = IS_START ? e2w_wsto_int : packet_w2e_wsti;
    // end tile loops its own east output back in
    assign e2w_esti_turned = IS_END ? w2e_esto_int : packet_e2w_esti;

    // core to router pipeline stage, second half of a hop
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sw2sr_q <= '0;
        end else if (clk_en) begin
            sw2sr_q <= packet_sw2sr;
        end
    end

    // own packet goes out in the tile's direction
    // the other direction passes straight through
    assign w2e_esto_int = IS_EVEN ? sw2sr_q : w2e_wsti_turned;
    assign e2w_wsto_int = IS_EVEN ? e2w_esti_turned : sw2sr_q;

    // switch listens on its upstream side, no register on this path
    assign packet_sr2sw = IS_EVEN ? w2e_wsti_turned : e2w_esti_turned;

    assign packet_w2e_esto = w2e_esto_int;
    assign packet_e2w_wsto = e2w_wsto_int;

    // frozen ring keeps both ring outputs
    a_hold_when_frozen : assert property (
        @(posedge clk) disable iff (reset)
        !clk_en |=> $stable(packet_w2e_esto) && $stable(packet_e2w_wsto)
    ) else $error("router %0d ring output changed while clk_en low", tile_id);

endmodule

`default_nettype wire

/* source/glb_core_switch.sv */
// per-tile control: executes, answers, delivers, forwards or injects packets
// one pending host request; host_req_valid is only taken while clk_en is high
// host_rsp_valid is shown for exactly one enabled cycle
// forwarded traffic always wins over injection
`timescale 1ns/1ps
`default_nettype none

module glb_core_switch #(
    parameter logic [glb_param_pkg::TILE_ID_WIDTH-1:0] tile_id = '0
) (
    input  logic                                      clk,
    input  logic                                      clk_en,
    input  logic                                      reset,

    input  glb_packet_pkg::packet_t                   packet_sr2sw,
    output glb_packet_pkg::packet_t                   packet_sw2sr,

    input  logic                                      host_req_valid,
    input  logic                                      host_req_write,
    input  logic [glb_param_pkg::TILE_ID_WIDTH-1:0]   host_req_dst,
    input  logic [glb_param_pkg::BANK_ADDR_WIDTH-1:0] host_req_addr,
    input  logic [glb_param_pkg::DATA_WIDTH-1:0]      host_req_data,
    output logic                                      host_req_busy,
    output logic                                      host_rsp_valid,
    output logic [glb_param_pkg::DATA_WIDTH-1:0]      host_rsp_data,

    glb_bank_if.ctrl                                  bank
);

    import glb_param_pkg::*;
    import glb_packet_pkg::*;

    packet_t in_pkt;
    packet_t out_d;
    packet_t out_q;
    packet_t pend_pkt;
    logic    pend_valid;
    logic    rsp_d;
    logic    rsp_q;
    logic    rsp_valid_q;
    logic    exec_wr;
    logic    exec_rd;
    logic    deliver;
    logic    forward;
    logic    inject;
    logic    accept;

    assign in_pkt = packet_sr2sw;

    // decode by opcode and own id
    assign exec_wr = (in_pkt.kind == PKT_WR) && (in_pkt.dst == tile_id);
    assign exec_rd = (in_pkt.kind == PKT_RD) && (in_pkt.dst == tile_id);
    assign deliver = (in_pkt.kind == PKT_RSP) && (in_pkt.src == tile_id);
    assign forward = (in_pkt.kind != PKT_NONE) && !exec_wr && !exec_rd && !deliver;

    // new host request only when nothing is pending
    assign accept = clk_en && host_req_valid && !pend_valid;

    // bank access in the arrival cycle
    assign bank.wr_en   = clk_en && exec_wr;
    assign bank.rd_en   = clk_en && exec_rd;
    assign bank.addr    = in_pkt.addr;
    assign bank.wr_data = in_pkt.data;

    // next outgoing slot
    always_comb begin
        out_d  = '0;
        rsp_d  = 1'b0;
        inject = 1'b0;
        if (exec_rd) begin
            // header now, data from the bank next cycle
            out_d      = in_pkt;
            out_d.kind = PKT_RSP;
            rsp_d      = 1'b1;
        end else if (forward) begin
            out_d = in_pkt;
        end else if (pend_valid) begin
            // free slot, either empty, written or delivered
            out_d  = pend_pkt;
            inject = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_q       <= '0;
            rsp_q       <= 1'b0;
            pend_valid  <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else if (clk_en) begin
            out_q       <= out_d;
            rsp_q       <= rsp_d;
            rsp_valid_q <= deliver;
            if (accept) begin
                pend_valid <= 1'b1;
            end else if (inject) begin
                pend_valid <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_pkt.kind <= host_req_write ? PKT_WR : PKT_RD;
            pend_pkt.src  <= tile_id;
            pend_pkt.dst  <= host_req_dst;
            pend_pkt.addr <= host_req_addr;
            pend_pkt.data <= host_req_data;
        end
        if (clk_en && deliver) begin
            host_rsp_data <= in_pkt.data;
        end
    end

    // response data is patched in from the bank read
    always_comb begin
        packet_sw2sr = out_q;
        if (rsp_q) begin
            packet_sw2sr.data = bank.rd_data;
        end
    end

    assign host_req_busy  = pend_valid;
    // held value stays hidden while frozen
    assign host_rsp_valid = rsp_valid_q && clk_en;

    a_no_strobe_busy : assert property (
        @(posedge clk) disable iff (reset)
        host_req_valid |-> !host_req_busy
    ) else $error("switch %0d host strobe while busy", tile_id);

    // a response leaves with this tile as dst only when it was made here
    a_rsp_dst_own : assert property (
        @(posedge clk) disable iff (reset)
        (out_q.kind == PKT_RSP) |-> ((out_q.dst == tile_id) == rsp_q)
    ) else $error("switch %0d response with wrong dst", tile_id);

endmodule

`default_nettype wire

/* source/glb_bank.sv */
// single-port bank, BANK_DEPTH words of DATA_WIDTH bits
// write on wr_en, read data registered on rd_en and held otherwise
// contents are undefined after reset
`timescale 1ns/1ps
`default_nettype none

module glb_bank (
    input  logic    clk,
    glb_bank_if.mem bank
);

    import glb_param_pkg::*;

    // storage
    logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (bank.wr_en) begin
            mem[bank.addr] <= bank.wr_data;
        end
    end

    // read port, one cycle latency
    // rd_data keeps its value between reads
    always_ff @(posedge clk) begin
        if (bank.rd_en) begin
            bank.rd_data <= mem[bank.addr];
        end
    end

    // single port, a read and a write never share a cycle
    a_rd_wr_excl : assert property (
        @(posedge clk)
        bank.wr_en |-> !bank.rd_en
    ) else $error("bank read and write in the same cycle");

endmodule

`default_nettype wire

/* source/glb_strm_top.sv */
// ring of NUM_TILES global buffer tiles, loop order 0, 2, .., 3, 1
// host ports are packed per-tile vectors, index i belongs to tile i
// strobe only while the matching busy bit is low
// clk_en low freezes every tile
`timescale 1ns/1ps
`default_nettype none

module glb_strm_top (
    input  logic clk,
    input  logic reset,
    input  logic clk_en,

    input  logic [glb_param_pkg::NUM_TILES-1:0] host_req_valid,
    input  logic [glb_param_pkg::NUM_TILES-1:0] host_req_write,
    input  logic [glb_param_pkg::NUM_TILES-1:0][glb_param_pkg::TILE_ID_WIDTH-1:0]
                 host_req_dst,
    input  logic [glb_param_pkg::NUM_TILES-1:0][glb_param_pkg::BANK_ADDR_WIDTH-1:0]
                 host_req_addr,
    input  logic [glb_param_pkg::NUM_TILES-1:0][glb_param_pkg::DATA_WIDTH-1:0]
                 host_req_data,
    output logic [glb_param_pkg::NUM_TILES-1:0] host_req_busy,
    output logic [glb_param_pkg::NUM_TILES-1:0] host_rsp_valid,
    output logic [glb_param_pkg::NUM_TILES-1:0][glb_param_pkg::DATA_WIDTH-1:0]
                 host_rsp_data
);

    import glb_param_pkg::*;
    import glb_packet_pkg::*;

    // ring wires, indexed by the driving tile
    packet_t w2e_esto [NUM_TILES];
    packet_t e2w_wsto [NUM_TILES];

    genvar i;
    generate
        for (i = 0; i < NUM_TILES; i++) begin : g_tile
            packet_t w2e_wsti;
            packet_t e2w_esti;
            packet_t sw2sr;
            packet_t sr2sw;

            // outer ends are tied off, the turnaround replaces them
            if (i == 0) begin : g_west_end
                assign w2e_wsti = '0;
            end else begin : g_west_link
                assign w2e_wsti = w2e_esto[i-1];
            end

            if (i == NUM_TILES - 1) begin : g_east_end
                assign e2w_esti = '0;
            end else begin : g_east_link
                assign e2w_esti = e2w_wsto[i+1];
            end

            glb_bank_if bank_if ();

            glb_core_strm_router #(
                .tile_id (TILE_ID_WIDTH'(i))
            ) i_router (
                .clk             (clk),
                .clk_en          (clk_en),
                .reset           (reset),
                .packet_w2e_wsti (w2e_wsti),
                .packet_e2w_wsto (e2w_wsto[i]),
                .packet_e2w_esti (e2w_esti),
                .packet_w2e_esto (w2e_esto[i]),
                .packet_sw2sr    (sw2sr),
                .packet_sr2sw    (sr2sw)
            );

            glb_core_switch #(
                .tile_id (TILE_ID_WIDTH'(i))
            ) i_switch (
                .clk            (clk),
                .clk_en         (clk_en),
                .reset          (reset),
                .packet_sr2sw   (sr2sw),
                .packet_sw2sr   (sw2sr),
                .host_req_valid (host_req_valid[i]),
                .host_req_write (host_req_write[i]),
                .host_req_dst   (host_req_dst[i]),
                .host_req_addr  (host_req_addr[i]),
                .host_req_data  (host_req_data[i]),
                .host_req_busy  (host_req_busy[i]),
                .host_rsp_valid (host_rsp_valid[i]),
                .host_rsp_data  (host_rsp_data[i]),
                .bank           (bank_if.ctrl)
            );

            glb_bank i_bank (
                .clk  (clk),
                .bank (bank_if.mem)
            );
        end
    endgenerate

endmodule

`default_nettype wire

/* test/glb_clk_gen.sv */
// testbench clock and power-on reset
// reset is high from time zero and drops on a falling edge
`timescale 1ns/1ps
`default_nettype none

module glb_clk_gen #(
    parameter real period_ns    = 4.0,
    parameter int  reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // reset held over the first rising edges
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* test/glb_strm_tb.sv */
// testbench for the tile ring; one read in flight per host at a time
// model word is updated only after the idle-ring write landing time
// checks are concurrent assertions sampled on the rising edge
`timescale 1ns/1ps
`default_nettype none

module glb_strm_tb;

    import glb_param_pkg::*;

    localparam int SEED        = 34088;
    localparam int RD_BOUND    = 4 * NUM_TILES + 4;
    localparam int WR_LAND     = 2 * NUM_TILES + 3;
    localparam int RAND_ROUNDS = 4;
    localparam int FREEZE_MAX  = 24;
    // ops of all tests, each given a full read bound
    localparam int NUM_OPS = 2 * NUM_TILES + 3 * NUM_TILES * NUM_TILES
                             + RAND_ROUNDS * NUM_TILES + NUM_TILES;
    localparam int TIMEOUT_CYCLES = (NUM_OPS * RD_BOUND + 2 * FREEZE_MAX + 20) * 3 / 2;

    logic clk;
    logic reset;
    logic clk_en;
    logic [NUM_TILES-1:0]                      host_req_valid;
    logic [NUM_TILES-1:0]                      host_req_write;
    logic [NUM_TILES-1:0][TILE_ID_WIDTH-1:0]   host_req_dst;
    logic [NUM_TILES-1:0][BANK_ADDR_WIDTH-1:0] host_req_addr;
    logic [NUM_TILES-1:0][DATA_WIDTH-1:0]      host_req_data;
    logic [NUM_TILES-1:0]                      host_req_busy;
    logic [NUM_TILES-1:0]                      host_rsp_valid;
    logic [NUM_TILES-1:0][DATA_WIDTH-1:0]      host_rsp_data;

    // reference memory, one array per tile
    logic [DATA_WIDTH-1:0] model [NUM_TILES][BANK_DEPTH];
    int known_tile [$];
    int known_addr [$];

    // per host read tracking
    logic [NUM_TILES-1:0]  outstanding;
    logic [DATA_WIDTH-1:0] exp_data [NUM_TILES] = '{default: '0};
    int                    lat_cnt [NUM_TILES] = '{default: 0};
    logic                  bound_on;

    int errors      = 0;
    int tests_run   = 0;
    int reads_done  = 0;
    int writes_done = 0;
    int rsp_count   = 0;
    int cycle_count = 0;

    glb_clk_gen #(.period_ns(4.0), .reset_cycles(3)) i_clk_gen (.clk(clk), .reset(reset));

    glb_strm_top i_glb_strm_top (
        .clk            (clk),
        .reset          (reset),
        .clk_en         (clk_en),
        .host_req_valid (host_req_valid),
        .host_req_write (host_req_write),
        .host_req_dst   (host_req_dst),
        .host_req_addr  (host_req_addr),
        .host_req_data  (host_req_data),
        .host_req_busy  (host_req_busy),
        .host_rsp_valid (host_rsp_valid),
        .host_rsp_data  (host_rsp_data)
    );

    // response tracking, latency counts enabled cycles only
    always @(posedge clk) begin
        for (int t = 0; t < NUM_TILES; t++) begin
            if (clk_en && outstanding[t]) begin
                lat_cnt[t]++;
            end
            if (host_rsp_valid[t] && outstanding[t]) begin
                outstanding[t] = 1'b0;
                rsp_count++;
            end
        end
    end

    // run length guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    a_idle_after_reset : assert property (@(posedge clk)
        $fell(reset) |-> (host_req_busy == '0) && (host_rsp_valid == '0)
    ) else begin
        errors++;
        $display("busy or response valid high right after reset");
    end

    // frozen ring shows no response and keeps busy
    a_no_rsp_frozen : assert property (@(posedge clk) disable iff (reset)
        !clk_en |-> (host_rsp_valid == '0)
    ) else begin
        errors++;
        $display("response valid pulsed while clk_en low");
    end

    a_busy_frozen : assert property (@(posedge clk) disable iff (reset)
        !clk_en |=> $stable(host_req_busy)
    ) else begin
        errors++;
        $display("busy changed while clk_en low");
    end

    genvar g;
    generate
        for (g = 0; g < NUM_TILES; g++) begin : g_chk
            // responses only where a read is waiting
            a_rsp_expected : assert property (@(posedge clk) disable iff (reset)
                host_rsp_valid[g] |-> outstanding[g]
            ) else begin
                errors++;
                $display("tile %0d got a response with no read outstanding", g);
            end

            a_rsp_data : assert property (@(posedge clk) disable iff (reset)
                (host_rsp_valid[g] && outstanding[g]) |-> (host_rsp_data[g] == exp_data[g])
            ) else begin
                errors++;
                $display("MISMATCH host_rsp_data[%0d] got 0x%h expected 0x%h",
                         g, $sampled(host_rsp_data[g]), $sampled(exp_data[g]));
            end

            a_rsp_not_busy : assert property (@(posedge clk) disable iff (reset)
                host_rsp_valid[g] |-> !host_req_busy[g]
            ) else begin
                errors++;
                $display("tile %0d busy still high when its response arrived", g);
            end

            a_rd_latency : assert property (@(posedge clk) disable iff (reset)
                (bound_on && outstanding[g]) |-> (lat_cnt[g] <= RD_BOUND)
            ) else begin
                errors++;
                $display("tile %0d read took over %0d enabled cycles", g, RD_BOUND);
            end
        end
    endgenerate

    // strobe a write, then wait out the landing time
    task automatic write_word(input int src, input int dst, input int addr,
                              input logic [DATA_WIDTH-1:0] data);
        @(negedge clk);
        while (host_req_busy[src]) @(negedge clk);
        host_req_valid[src] = 1'b1;
        host_req_write[src] = 1'b1;
        host_req_dst[src]   = TILE_ID_WIDTH'(dst);
        host_req_addr[src]  = BANK_ADDR_WIDTH'(addr);
        host_req_data[src]  = data;
        @(negedge clk);
        host_req_valid[src] = 1'b0;
        repeat (WR_LAND) @(negedge clk);
        model[dst][addr] = data;
        known_tile.push_back(dst);
        known_addr.push_back(addr);
        writes_done++;
    endtask

    // strobe a read and wait for its response
    task automatic read_word(input int src, input int dst, input int addr);
        @(negedge clk);
        while (host_req_busy[src]) @(negedge clk);
        host_req_valid[src] = 1'b1;
        host_req_write[src] = 1'b0;
        host_req_dst[src]   = TILE_ID_WIDTH'(dst);
        host_req_addr[src]  = BANK_ADDR_WIDTH'(addr);
        host_req_data[src]  = '0;
        exp_data[src]       = model[dst][addr];
        lat_cnt[src]        = 0;
        outstanding[src]    = 1'b1;
        @(negedge clk);
        host_req_valid[src] = 1'b0;
        while (outstanding[src]) @(negedge clk);
        reads_done++;
    endtask

    // latest written address in a tile
    function automatic int known_addr_of(input int tile);
        int addr;
        addr = 0;
        foreach (known_tile[k]) begin
            if (known_tile[k] == tile) addr = known_addr[k];
        end
        return addr;
    endfunction

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errors == err_start) ? "ok" : "FAILED", errors - err_start);
    endtask

    initial begin
        int err_start;
        int reader;
        void'($urandom(SEED));
        clk_en         = 1'b1;
        host_req_valid = '0;
        host_req_write = '0;
        host_req_dst   = '0;
        host_req_addr  = '0;
        host_req_data  = '0;
        outstanding    = '0;
        bound_on       = 1'b0;
        @(negedge reset);
        repeat (2) @(negedge clk);
        report_test("reset state", 0);

        // local write then read back
        err_start = errors;
        bound_on  = 1'b1;
        for (int t = 0; t < NUM_TILES; t++) begin
            write_word(t, t, $urandom_range(BANK_DEPTH - 1), DATA_WIDTH'($urandom));
            read_word(t, t, known_addr_of(t));
        end
        report_test("local write/read", err_start);

        // every source and destination, read back by a third tile
        err_start = errors;
        for (int s = 0; s < NUM_TILES; s++) begin
            for (int d = 0; d < NUM_TILES; d++) begin
                reader = (s + 1) % NUM_TILES;
                if (reader == d) reader = (s + 2) % NUM_TILES;
                write_word(s, d, $urandom_range(BANK_DEPTH - 1), DATA_WIDTH'($urandom));
                read_word(reader, d, known_addr_of(d));
            end
        end
        report_test("cross-tile", err_start);

        // all hosts at once, injection contends with forwarding
        err_start = errors;
        bound_on  = 1'b0;
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            for (int t = 0; t < NUM_TILES; t++) begin
                fork
                    automatic int tt = t;
                    automatic int k  = $urandom_range(known_tile.size() - 1);
                    read_word(tt, known_tile[k], known_addr[k]);
                join_none
            end
            wait fork;
        end
        report_test("concurrent reads", err_start);

        // idle ring latency for every pair
        err_start = errors;
        bound_on  = 1'b1;
        for (int s = 0; s < NUM_TILES; s++) begin
            for (int d = 0; d < NUM_TILES; d++) begin
                read_word(s, d, known_addr_of(d));
            end
        end
        report_test("idle latency", err_start);

        // freeze with reads in flight
        err_start = errors;
        bound_on  = 1'b0;
        for (int t = 0; t < NUM_TILES; t++) begin
            fork
                automatic int tt = t;
                automatic int d  = $urandom_range(NUM_TILES - 1);
                read_word(tt, d, known_addr_of(d));
            join_none
        end
        fork
            begin
                // first stop while every host still holds its request
                repeat (2) @(negedge clk);
                clk_en = 1'b0;
                repeat ($urandom_range(FREEZE_MAX, 4)) @(negedge clk);
                clk_en = 1'b1;
                // second stop with the packets out in the ring
                repeat ($urandom_range(6, 3)) @(negedge clk);
                clk_en = 1'b0;
                repeat ($urandom_range(FREEZE_MAX, 4)) @(negedge clk);
                clk_en = 1'b1;
            end
        join_none
        wait fork;
        report_test("clk_en freeze", err_start);

        $display("tests %0d, reads %0d, writes %0d, responses %0d, errors %0d",
                 tests_run, reads_done, writes_done, rsp_count, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* glb_strm_top.f */
source/glb_param_pkg.sv
source/glb_packet_pkg.sv
source/glb_bank_if.sv
source/glb_core_strm_router.sv
source/glb_core_switch.sv
source/glb_bank.sv
source/glb_strm_top.sv
test/glb_clk_gen.sv
test/glb_strm_tb.sv
